// File: Bender.yml
package:
  name: job_ctrl

sources:
  - common/axil_pkg.sv
  - common/job_regs_pkg.sv
  - common/reg_access_if.sv
  - common/action_status_if.sv
  - src/axil_port/axil_slave_port.sv
  - src/reg_file/job_reg_file.sv
  - src/action_ctrl.sv
  - src/job_ctrl_top.sv
  - target: simulation
    files:
      - sim/job_ctrl_tb.sv

// File: common/action_status_if.sv
//------------------------------
// Start, soft reset and status levels between the
// register file and the action control
//------------------------------
`timescale 1ns/100ps

interface action_status_if;

   // From the register file
   logic ctrl_start;
   logic soft_reset;

   // From the action control
   logic start_q;
   logic idle;
   logic done;
   logic wr_err;
   logic rd_err;

   modport regs (
      output ctrl_start, soft_reset,
      input  start_q, idle, done, wr_err, rd_err
   );

   modport ctrl (
      input  ctrl_start, soft_reset,
      output start_q, idle, done, wr_err, rd_err
   );

endinterface

// File: common/axil_pkg.sv
//------------------------------
// AXI4-Lite bus widths, strobe width and response codes
// Imported by the slave port and the register access interface
//------------------------------
package axil_pkg;

   // Bus geometry
   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [AXIL_DATA_W-1:0] axil_data_t;
   typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
   typedef logic [1:0]             axil_resp_t;

   // Response codes
   // Only OKAY is ever returned by this slave
   localparam axil_resp_t RESP_OKAY = 2'b00;

endpackage

// File: common/job_regs_pkg.sv
//------------------------------
// Job control register map, field positions and job types
// Imported by the register file and used for the top level job ports
//------------------------------
package job_regs_pkg;

   localparam int REG_W      = 32;
   localparam int JOB_ADDR_W = 64;
   localparam int MB_DIM_W   = 10;

   // Register offsets, byte addressed
   localparam logic [REG_W-1:0] OFS_ACTION_CONTROL = 32'h00;
   localparam logic [REG_W-1:0] OFS_ACTION_TYPE    = 32'h10;
   localparam logic [REG_W-1:0] OFS_ACTION_VERSION = 32'h14;
   localparam logic [REG_W-1:0] OFS_USER_STATUS    = 32'h30;
   localparam logic [REG_W-1:0] OFS_USER_CONTROL   = 32'h34;
   localparam logic [REG_W-1:0] OFS_SOURCE_ADDR_L  = 32'h38;
   localparam logic [REG_W-1:0] OFS_SOURCE_ADDR_H  = 32'h3C;
   localparam logic [REG_W-1:0] OFS_TARGET_ADDR_L  = 32'h40;
   localparam logic [REG_W-1:0] OFS_TARGET_ADDR_H  = 32'h44;
   localparam logic [REG_W-1:0] OFS_MB_W           = 32'h48;
   localparam logic [REG_W-1:0] OFS_MB_H           = 32'h4C;
   localparam logic [REG_W-1:0] OFS_SOFT_RESET     = 32'h50;

   // Returned for any offset not in the map
   localparam logic [REG_W-1:0] UNMAPPED_READ_VALUE = 32'h5A5AA5A5;

   // User control and soft reset fields
   localparam int START_BIT      = 0;
   localparam int SOFT_RESET_BIT = 0;

   // Action control fields
   localparam int CTRL_START_BIT = 0;
   localparam int CTRL_IDLE_BIT  = 2;
   localparam int CTRL_READY_BIT = 3;

   // User status fields, all sticky
   localparam int STAT_DONE_BIT   = 0;
   localparam int STAT_WR_ERR_BIT = 1;
   localparam int STAT_RD_ERR_BIT = 2;

   typedef logic [JOB_ADDR_W-1:0] job_addr_t;
   typedef logic [MB_DIM_W-1:0]   mb_dim_t;

endpackage

// File: common/reg_access_if.sv
//------------------------------
// Register write and read accesses from the bus port
// The port modport issues them, the regs modport answers reads
//------------------------------
`timescale 1ns/100ps

interface reg_access_if;

   import axil_pkg::*;

   // Write access, one cycle per data handshake
   logic       wr_en;
   axil_addr_t wr_addr;
   axil_data_t wr_data;
   axil_strb_t wr_strb;

   // Read access, data is combinational from rd_addr
   logic       rd_en;
   axil_addr_t rd_addr;
   axil_data_t rd_data;

   modport port (
      output wr_en, wr_addr, wr_data, wr_strb,
      output rd_en, rd_addr,
      input  rd_data
   );

   modport regs (
      input  wr_en, wr_addr, wr_data, wr_strb,
      input  rd_en, rd_addr,
      output rd_data
   );

endinterface

// File: job_ctrl.f
common/axil_pkg.sv
common/job_regs_pkg.sv
common/reg_access_if.sv
common/action_status_if.sv
src/axil_port/axil_slave_port.sv
src/reg_file/job_reg_file.sv
src/action_ctrl.sv
src/job_ctrl_top.sv
sim/job_ctrl_tb.sv

// File: sim/job_ctrl_tb.sv
//------------------------------
// Self-checking testbench for the job control block
// Drives AXI4-Lite writes and reads and tracks a register model
// Concurrent assertions compare the DUT with the model
//------------------------------
`timescale 1ns/100ps

module job_ctrl_tb;

   import axil_pkg::*;
   import job_regs_pkg::*;

   localparam int CLK_PERIOD = 40;
   // Upper bound on bus transactions issued by the tests
   localparam int NUM_TRANS  = 100;

   logic       clk;
   logic       rst_n;
   axil_addr_t s_axi_awaddr;
   logic       s_axi_awvalid;
   logic       s_axi_awready;
   axil_data_t s_axi_wdata;
   axil_strb_t s_axi_wstrb;
   logic       s_axi_wvalid;
   logic       s_axi_wready;
   axil_resp_t s_axi_bresp;
   logic       s_axi_bvalid;
   logic       s_axi_bready;
   axil_addr_t s_axi_araddr;
   logic       s_axi_arvalid;
   logic       s_axi_arready;
   axil_data_t s_axi_rdata;
   axil_resp_t s_axi_rresp;
   logic       s_axi_rvalid;
   logic       s_axi_rready;
   logic       start_pulse;
   job_addr_t  source_address;
   job_addr_t  target_address;
   axil_data_t mb_w;
   axil_data_t mb_h;
   mb_dim_t    w1;
   mb_dim_t    w2;
   mb_dim_t    h1;
   logic       done_pulse;
   logic       rd_error;
   logic       wr_error;
   axil_data_t action_type;
   axil_data_t action_version;

   // Register model
   axil_data_t exp_ctrl;
   axil_data_t exp_uctrl;
   axil_data_t exp_srst;
   axil_data_t exp_mbw;
   axil_data_t exp_mbh;
   job_addr_t  exp_src;
   job_addr_t  exp_tgt;
   mb_dim_t    exp_w1;
   mb_dim_t    exp_w2;
   mb_dim_t    exp_h1;
   logic       exp_done;
   logic       exp_wr_err;
   logic       exp_rd_err;
   logic       exp_idle;

   axil_addr_t wr_addr_cur;
   axil_data_t rd_exp;
   int         err_cnt;
   int         wr_cnt;
   int         rd_cnt;

   job_ctrl_top DUT (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic report_error(input string msg);
      err_cnt++;
      $display("[ERROR] %0t ns: %s", $time, msg);
   endtask

   //------------------------------
   // Register model
   //------------------------------

   // Byte lanes with a strobe take the new data
   function automatic axil_data_t strobe_merge(input axil_data_t old_v,
                                               input axil_data_t new_v,
                                               input axil_strb_t strb);
      axil_data_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_v & ~mask) | (new_v & mask);
   endfunction

   function automatic axil_data_t model_value(input axil_addr_t addr);
      case (addr)
         OFS_ACTION_CONTROL: return exp_ctrl;
         OFS_USER_CONTROL:   return exp_uctrl;
         OFS_SOURCE_ADDR_L:  return exp_src[31:0];
         OFS_SOURCE_ADDR_H:  return exp_src[63:32];
         OFS_TARGET_ADDR_L:  return exp_tgt[31:0];
         OFS_TARGET_ADDR_H:  return exp_tgt[63:32];
         OFS_MB_W:           return exp_mbw;
         OFS_MB_H:           return exp_mbh;
         OFS_SOFT_RESET:     return exp_srst;
         default:            return 32'h0;
      endcase
   endfunction

   function automatic axil_data_t expected_read(input axil_addr_t addr);
      case (addr)
         // Ready forced high with idle and start history in the low nibble
         OFS_ACTION_CONTROL: return {exp_ctrl[31:4], 1'b1, exp_idle, 1'b0, exp_ctrl[0]};
         OFS_ACTION_TYPE:    return action_type;
         OFS_ACTION_VERSION: return action_version;
         OFS_USER_STATUS:    return {29'd0, exp_rd_err, exp_wr_err, exp_done};
         default:            return (addr > 32'h50 || (addr > 32'h00 && addr < 32'h10) ||
                                     (addr > 32'h14 && addr < 32'h30)) ?
                                    32'h5A5AA5A5 : model_value(addr);
      endcase
   endfunction

   task automatic clear_model();
      exp_ctrl   = '0;
      exp_uctrl  = '0;
      exp_srst   = '0;
      exp_mbw    = '0;
      exp_mbh    = '0;
      exp_src    = '0;
      exp_tgt    = '0;
      exp_w1     = '0;
      exp_w2     = '0;
      exp_h1     = '0;
      exp_done   = 1'b0;
      exp_wr_err = 1'b0;
      exp_rd_err = 1'b0;
      exp_idle   = 1'b0;
   endtask

   // Called on the falling edge after the data handshake
   task automatic update_model(input axil_addr_t addr, input axil_data_t data,
                               input axil_strb_t strb);
      axil_data_t merged;
      merged = strobe_merge(model_value(addr), data, strb);
      case (addr)
         OFS_ACTION_CONTROL: exp_ctrl = merged;
         // Start bit self clears
         OFS_USER_CONTROL:   exp_uctrl = {merged[31:1], 1'b0};
         OFS_SOURCE_ADDR_L:  exp_src[31:0] = merged;
         OFS_SOURCE_ADDR_H:  exp_src[63:32] = merged;
         OFS_TARGET_ADDR_L:  exp_tgt[31:0] = merged;
         OFS_TARGET_ADDR_H:  exp_tgt[63:32] = merged;
         OFS_MB_W: begin
            exp_mbw = merged;
            exp_w1  = merged[9:0] - 10'd1;
            exp_w2  = merged[9:0] - 10'd2;
         end
         OFS_MB_H: begin
            exp_mbh = merged;
            exp_h1  = merged[9:0] - 10'd1;
         end
         OFS_SOFT_RESET: begin
            if (merged[0]) begin
               // Clear lands one cycle after the write
               @(negedge clk);
               clear_model();
            end else begin
               exp_srst = merged;
            end
         end
         default: ;
      endcase
   endtask

   //------------------------------
   // Bus tasks
   //------------------------------
   task automatic bus_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
      int delay;
      delay = $urandom_range(0, 4);
      @(negedge clk);
      wr_addr_cur   = addr;
      s_axi_awaddr  = addr;
      s_axi_awvalid = 1'b1;
      while (!s_axi_awready) begin
         @(negedge clk);
      end
      @(negedge clk);
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = data;
      s_axi_wstrb   = strb;
      s_axi_wvalid  = 1'b1;
      while (!s_axi_wready) begin
         @(negedge clk);
      end
      @(negedge clk);
      s_axi_wvalid = 1'b0;
      update_model(addr, data, strb);
      // Back-pressure on the response
      repeat (delay) @(negedge clk);
      s_axi_bready = 1'b1;
      while (!s_axi_bvalid) begin
         @(negedge clk);
      end
      @(negedge clk);
      s_axi_bready = 1'b0;
      wr_cnt++;
   endtask

   task automatic bus_read_check(input axil_addr_t addr);
      int delay;
      delay  = $urandom_range(0, 4);
      rd_exp = expected_read(addr);
      @(negedge clk);
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      while (!s_axi_arready) begin
         @(negedge clk);
      end
      @(negedge clk);
      s_axi_arvalid = 1'b0;
      repeat (delay) @(negedge clk);
      s_axi_rready = 1'b1;
      while (!s_axi_rvalid) begin
         @(negedge clk);
      end
      @(negedge clk);
      s_axi_rready = 1'b0;
      rd_cnt++;
   endtask

   // One cycle pulse on the status inputs
   task automatic pulse_status(input logic done_v, input logic wr_v, input logic rd_v);
      @(negedge clk);
      done_pulse = done_v;
      wr_error   = wr_v;
      rd_error   = rd_v;
      @(negedge clk);
      done_pulse = 1'b0;
      wr_error   = 1'b0;
      rd_error   = 1'b0;
      exp_done   = exp_done | done_v;
      exp_idle   = exp_idle | done_v;
      exp_wr_err = exp_wr_err | wr_v;
      exp_rd_err = exp_rd_err | rd_v;
   endtask

   //------------------------------
   // Assertions
   //------------------------------
   a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_rvalid && s_axi_rready |-> s_axi_rdata == rd_exp)
      else report_error("read data differs from the register model");

   a_outputs: assert property (@(posedge clk) disable iff (!rst_n)
      source_address == exp_src && target_address == exp_tgt &&
      mb_w == exp_mbw && mb_h == exp_mbh)
      else report_error("job setup outputs differ from the register model");

   a_sizes: assert property (@(posedge clk) disable iff (!rst_n)
      w1 == exp_w1 && w2 == exp_w2 && h1 == exp_h1)
      else report_error("derived sizes w1, w2 or h1 are wrong");

   a_start: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_wvalid && s_axi_wready && wr_addr_cur == OFS_USER_CONTROL &&
      s_axi_wstrb[0] && s_axi_wdata[0] |=> start_pulse ##1 !start_pulse)
      else report_error("start_pulse is not one cycle wide after the write");

   a_start_src: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(start_pulse) |-> $past(s_axi_wvalid && s_axi_wready))
      else report_error("start_pulse rose without a write handshake");

   a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_bvalid |-> s_axi_bresp == 2'b00)
      else report_error("write response code is not OKAY");

   a_rresp: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_rvalid |-> s_axi_rresp == 2'b00)
      else report_error("read response code is not OKAY");

   a_bvalid: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_wvalid && s_axi_wready |=> s_axi_bvalid && s_axi_awready)
      else report_error("bvalid or awready wrong after the data handshake");

   a_bhold: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
      else report_error("bvalid dropped before bready");

   a_rhold: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
      else report_error("rvalid or rdata changed before rready");

   a_rdone: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_rvalid && s_axi_rready |=> !s_axi_rvalid && s_axi_arready)
      else report_error("rvalid or arready wrong after the read handshake");

   a_aw_take: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_awvalid && s_axi_awready |=> !s_axi_awready && s_axi_wready)
      else report_error("awready or wready wrong after the address handshake");

   a_aw_busy: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_wready |-> !s_axi_awready)
      else report_error("awready high while waiting for write data");

   a_ar_take: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_arvalid && s_axi_arready |=> s_axi_rvalid && !s_axi_arready)
      else report_error("arready or rvalid wrong after the address handshake");

   a_ar_busy: assert property (@(posedge clk) disable iff (!rst_n)
      s_axi_rvalid |-> !s_axi_arready)
      else report_error("arready high while read data is pending");

   //------------------------------
   // Stimulus
   //------------------------------
   initial begin
      int unsigned seed_init;
      axil_data_t  data;
      axil_addr_t  addr;
      seed_init      = $urandom(98);
      rst_n          = 1'b0;
      s_axi_awaddr   = '0;
      s_axi_awvalid  = 1'b0;
      s_axi_wdata    = '0;
      s_axi_wstrb    = '0;
      s_axi_wvalid   = 1'b0;
      s_axi_bready   = 1'b0;
      s_axi_araddr   = '0;
      s_axi_arvalid  = 1'b0;
      s_axi_rready   = 1'b0;
      done_pulse     = 1'b0;
      rd_error       = 1'b0;
      wr_error       = 1'b0;
      action_type    = $urandom();
      action_version = $urandom();
      wr_addr_cur    = '0;
      rd_exp         = '0;
      err_cnt        = 0;
      wr_cnt         = 0;
      rd_cnt         = 0;
      clear_model();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Sizes with random data and strobes
      repeat (8) begin
         bus_write(OFS_MB_W, $urandom(), axil_strb_t'($urandom_range(0, 15)));
         bus_read_check(OFS_MB_W);
         bus_write(OFS_MB_H, $urandom(), axil_strb_t'($urandom_range(0, 15)));
         bus_read_check(OFS_MB_H);
      end

      // Address halves of source then target
      for (int i = 0; i < 16; i++) begin
         addr = OFS_SOURCE_ADDR_L + 4 * (i % 4);
         bus_write(addr, $urandom(), axil_strb_t'($urandom_range(0, 15)));
         bus_read_check(addr);
      end

      // Start pulse and action start bit
      data = ($urandom() & 32'hFFFF_FFFE) | 32'h1;
      bus_write(OFS_USER_CONTROL, data, 4'hF);
      bus_read_check(OFS_USER_CONTROL);
      bus_write(OFS_ACTION_CONTROL, 32'h1, 4'hF);
      bus_read_check(OFS_ACTION_CONTROL);

      // Sticky status and idle
      pulse_status(1'b1, 1'b0, 1'b0);
      pulse_status(1'b0, 1'b1, 1'b0);
      pulse_status(1'b0, 1'b0, 1'b1);
      bus_read_check(OFS_USER_STATUS);
      bus_read_check(OFS_ACTION_CONTROL);

      // Soft reset then a sweep of the whole map including holes
      bus_write(OFS_SOFT_RESET, 32'h1, 4'h1);
      for (int a = 0; a <= 32'h54; a += 4) begin
         bus_read_check(axil_addr_t'(a));
      end
      bus_read_check(32'h100);

      repeat (4) @(negedge clk);
      $display("Summary: %0d writes, %0d reads, %0d errors", wr_cnt, rd_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(NUM_TRANS * 20 * CLK_PERIOD + 100 * CLK_PERIOD);
      $display("Timeout: the tests did not finish in time, %0d errors so far", err_cnt);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: src/action_ctrl.sv
//------------------------------
// Action start history, idle flag and sticky status
// All state is cleared by the soft reset level
//------------------------------
`timescale 1ns/100ps

module action_ctrl (
   input  logic          clk,
   input  logic          rst_n,
   action_status_if.ctrl st,
   input  logic          done_pulse,
   input  logic          rd_error,
   input  logic          wr_error
);

   // Start bit delayed by one cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         st.start_q <= 1'b0;
      end else if (st.soft_reset) begin
         st.start_q <= 1'b0;
      end else begin
         st.start_q <= st.ctrl_start;
      end
   end

   //------------------------------
   // Sticky flags
   //------------------------------

   // Job finished means idle and done together
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         st.idle   <= 1'b0;
         st.done   <= 1'b0;
         st.wr_err <= 1'b0;
         st.rd_err <= 1'b0;
      end else if (st.soft_reset) begin
         st.idle   <= 1'b0;
         st.done   <= 1'b0;
         st.wr_err <= 1'b0;
         st.rd_err <= 1'b0;
      end else begin
         if (done_pulse) begin
            st.idle <= 1'b1;
            st.done <= 1'b1;
         end
         if (wr_error) begin
            st.wr_err <= 1'b1;
         end
         if (rd_error) begin
            st.rd_err <= 1'b1;
         end
      end
   end

endmodule

// File: src/axil_port/axil_slave_port.sv
//------------------------------
// AXI4-Lite slave front end, one transaction at a time per direction
// Turns bus handshakes into single cycle register accesses
//------------------------------
`timescale 1ns/100ps

module axil_slave_port (
   input  logic                 clk,
   input  logic                 rst_n,
   // Write address channel
   input  axil_pkg::axil_addr_t awaddr,
   input  logic                 awvalid,
   output logic                 awready,
   // Write data channel
   input  axil_pkg::axil_data_t wdata,
   input  axil_pkg::axil_strb_t wstrb,
   input  logic                 wvalid,
   output logic                 wready,
   // Write response channel
   output axil_pkg::axil_resp_t bresp,
   output logic                 bvalid,
   input  logic                 bready,
   // Read address channel
   input  axil_pkg::axil_addr_t araddr,
   input  logic                 arvalid,
   output logic                 arready,
   // Read data channel
   output axil_pkg::axil_data_t rdata,
   output axil_pkg::axil_resp_t rresp,
   output logic                 rvalid,
   input  logic                 rready,
   // Register accesses
   reg_access_if.port           acc
);

   import axil_pkg::*;

   axil_addr_t wr_addr_q;

   //------------------------------
   // Write path
   //------------------------------

   // Address is taken first, data follows
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready <= 1'b1;
      end else if (awvalid) begin
         awready <= 1'b0;
      end else if (wvalid && wready) begin
         // Free again once the data beat is in
         awready <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wready <= 1'b0;
      end else if (awvalid && awready) begin
         wready <= 1'b1;
      end else if (wvalid) begin
         wready <= 1'b0;
      end
   end

   // Held for the data beat
   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         wr_addr_q <= awaddr;
      end
   end

   // Response one cycle after the data beat, held until bready
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bvalid <= 1'b0;
      end else if (wvalid && wready) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   assign acc.wr_en   = wvalid & wready;
   assign acc.wr_addr = wr_addr_q;
   assign acc.wr_data = wdata;
   assign acc.wr_strb = wstrb;

   //------------------------------
   // Read path
   //------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b1;
      end else if (arvalid) begin
         arready <= 1'b0;
      end else if (rvalid && rready) begin
         arready <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rvalid <= 1'b0;
      end else if (arvalid && arready) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   // Sampled once, stable while rvalid waits
   always_ff @(posedge clk) begin
      if (acc.rd_en) begin
         rdata <= acc.rd_data;
      end
   end

   assign acc.rd_en   = arvalid & arready;
   assign acc.rd_addr = araddr;

   // No error responses
   assign bresp = RESP_OKAY;
   assign rresp = RESP_OKAY;

endmodule

// File: src/job_ctrl_top.sv
//------------------------------
// Job control block top level
// Plain AXI4-Lite slave ports in, job setup and start pulse out
//------------------------------
`timescale 1ns/100ps

module job_ctrl_top (
   input  logic                    clk,
   input  logic                    rst_n,
   // AXI4-Lite slave
   input  axil_pkg::axil_addr_t    s_axi_awaddr,
   input  logic                    s_axi_awvalid,
   output logic                    s_axi_awready,
   input  axil_pkg::axil_data_t    s_axi_wdata,
   input  axil_pkg::axil_strb_t    s_axi_wstrb,
   input  logic                    s_axi_wvalid,
   output logic                    s_axi_wready,
   output axil_pkg::axil_resp_t    s_axi_bresp,
   output logic                    s_axi_bvalid,
   input  logic                    s_axi_bready,
   input  axil_pkg::axil_addr_t    s_axi_araddr,
   input  logic                    s_axi_arvalid,
   output logic                    s_axi_arready,
   output axil_pkg::axil_data_t    s_axi_rdata,
   output axil_pkg::axil_resp_t    s_axi_rresp,
   output logic                    s_axi_rvalid,
   input  logic                    s_axi_rready,
   // Job setup
   output logic                    start_pulse,
   output job_regs_pkg::job_addr_t source_address,
   output job_regs_pkg::job_addr_t target_address,
   output axil_pkg::axil_data_t    mb_w,
   output axil_pkg::axil_data_t    mb_h,
   output job_regs_pkg::mb_dim_t   w1,
   output job_regs_pkg::mb_dim_t   w2,
   output job_regs_pkg::mb_dim_t   h1,
   // Job status
   input  logic                    done_pulse,
   input  logic                    rd_error,
   input  logic                    wr_error,
   input  axil_pkg::axil_data_t    action_type,
   input  axil_pkg::axil_data_t    action_version
);

   reg_access_if    acc_if ();
   action_status_if st_if ();

   // Bus side
   axil_slave_port u_port (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (s_axi_awaddr),
      .awvalid (s_axi_awvalid),
      .awready (s_axi_awready),
      .wdata   (s_axi_wdata),
      .wstrb   (s_axi_wstrb),
      .wvalid  (s_axi_wvalid),
      .wready  (s_axi_wready),
      .bresp   (s_axi_bresp),
      .bvalid  (s_axi_bvalid),
      .bready  (s_axi_bready),
      .araddr  (s_axi_araddr),
      .arvalid (s_axi_arvalid),
      .arready (s_axi_arready),
      .rdata   (s_axi_rdata),
      .rresp   (s_axi_rresp),
      .rvalid  (s_axi_rvalid),
      .rready  (s_axi_rready),
      .acc     (acc_if.port)
   );

   // Job setup storage
   job_reg_file u_regs (
      .clk            (clk),
      .rst_n          (rst_n),
      .acc            (acc_if.regs),
      .st             (st_if.regs),
      .action_type    (action_type),
      .action_version (action_version),
      .start_pulse    (start_pulse),
      .source_address (source_address),
      .target_address (target_address),
      .mb_w           (mb_w),
      .mb_h           (mb_h),
      .w1             (w1),
      .w2             (w2),
      .h1             (h1)
   );

   // Start and done events
   action_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .st         (st_if.ctrl),
      .done_pulse (done_pulse),
      .rd_error   (rd_error),
      .wr_error   (wr_error)
   );

endmodule

// File: src/reg_file/job_reg_file.sv
//------------------------------
// Job setup registers with byte strobe merge and read mux
// Also derives w1, w2, h1 and drives the soft reset level
//------------------------------
`timescale 1ns/100ps

module job_reg_file (
   input  logic                    clk,
   input  logic                    rst_n,
   reg_access_if.regs              acc,
   action_status_if.regs           st,
   input  axil_pkg::axil_data_t    action_type,
   input  axil_pkg::axil_data_t    action_version,
   output logic                    start_pulse,
   output job_regs_pkg::job_addr_t source_address,
   output job_regs_pkg::job_addr_t target_address,
   output axil_pkg::axil_data_t    mb_w,
   output axil_pkg::axil_data_t    mb_h,
   output job_regs_pkg::mb_dim_t   w1,
   output job_regs_pkg::mb_dim_t   w2,
   output job_regs_pkg::mb_dim_t   h1
);

   import axil_pkg::*;
   import job_regs_pkg::*;

   axil_data_t ctrl_reg;
   axil_data_t user_ctrl;
   axil_data_t srst_reg;
   axil_data_t wr_old;
   axil_data_t wr_word;
   axil_data_t ctrl_rd;
   axil_data_t status_rd;
   logic       soft_reset;

   // Replace only the strobed bytes of the old value
   function automatic axil_data_t merge_bytes(input axil_data_t old_v,
                                              input axil_data_t new_v,
                                              input axil_strb_t strb);
      axil_data_t res;
      res = old_v;
      for (int i = 0; i < AXIL_STRB_W; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_v[8*i +: 8];
         end
      end
      return res;
   endfunction

   // Current value of the addressed word
   always_comb begin
      case (acc.wr_addr)
         OFS_ACTION_CONTROL: wr_old = ctrl_reg;
         OFS_USER_CONTROL:   wr_old = user_ctrl;
         OFS_SOURCE_ADDR_L:  wr_old = source_address[31:0];
         OFS_SOURCE_ADDR_H:  wr_old = source_address[63:32];
         OFS_TARGET_ADDR_L:  wr_old = target_address[31:0];
         OFS_TARGET_ADDR_H:  wr_old = target_address[63:32];
         OFS_MB_W:           wr_old = mb_w;
         OFS_MB_H:           wr_old = mb_h;
         OFS_SOFT_RESET:     wr_old = srst_reg;
         default:            wr_old = '0;
      endcase
   end

   assign wr_word    = merge_bytes(wr_old, acc.wr_data, acc.wr_strb);
   assign soft_reset = srst_reg[SOFT_RESET_BIT];

   //------------------------------
   // Register writes
   //------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_reg       <= '0;
         user_ctrl      <= '0;
         source_address <= '0;
         target_address <= '0;
         mb_w           <= '0;
         mb_h           <= '0;
         srst_reg       <= '0;
         w1             <= '0;
         w2             <= '0;
         h1             <= '0;
      end else if (soft_reset) begin
         ctrl_reg       <= '0;
         user_ctrl      <= '0;
         source_address <= '0;
         target_address <= '0;
         mb_w           <= '0;
         mb_h           <= '0;
         srst_reg       <= '0;
         w1             <= '0;
         w2             <= '0;
         h1             <= '0;
      end else if (acc.wr_en) begin
         case (acc.wr_addr)
            OFS_ACTION_CONTROL: ctrl_reg <= wr_word;
            OFS_USER_CONTROL:   user_ctrl <= wr_word;
            OFS_SOURCE_ADDR_L:  source_address <= {source_address[63:32], wr_word};
            OFS_SOURCE_ADDR_H:  source_address <= {wr_word, source_address[31:0]};
            OFS_TARGET_ADDR_L:  target_address <= {target_address[63:32], wr_word};
            OFS_TARGET_ADDR_H:  target_address <= {wr_word, target_address[31:0]};
            OFS_MB_W: begin
               mb_w <= wr_word;
               // Sizes minus one and two in the low bits
               w1   <= wr_word[MB_DIM_W-1:0] - mb_dim_t'(1);
               w2   <= wr_word[MB_DIM_W-1:0] - mb_dim_t'(2);
            end
            OFS_MB_H: begin
               mb_h <= wr_word;
               h1   <= wr_word[MB_DIM_W-1:0] - mb_dim_t'(1);
            end
            OFS_SOFT_RESET:     srst_reg <= wr_word;
            default: ;
         endcase
      end else begin
         // Self clearing bits
         user_ctrl[START_BIT]      <= 1'b0;
         srst_reg[SOFT_RESET_BIT]  <= 1'b0;
      end
   end

   assign start_pulse   = user_ctrl[START_BIT];
   assign st.ctrl_start = ctrl_reg[CTRL_START_BIT];
   assign st.soft_reset = soft_reset;

   //------------------------------
   // Read mux
   //------------------------------

   // Action control view with the low nibble from live status
   always_comb begin
      ctrl_rd                 = {ctrl_reg[31:4], 4'b0000};
      ctrl_rd[CTRL_READY_BIT] = 1'b1;
      ctrl_rd[CTRL_IDLE_BIT]  = st.idle;
      ctrl_rd[CTRL_START_BIT] = st.start_q;
   end

   always_comb begin
      status_rd                  = '0;
      status_rd[STAT_DONE_BIT]   = st.done;
      status_rd[STAT_WR_ERR_BIT] = st.wr_err;
      status_rd[STAT_RD_ERR_BIT] = st.rd_err;
   end

   always_comb begin
      case (acc.rd_addr)
         OFS_ACTION_CONTROL: acc.rd_data = ctrl_rd;
         OFS_ACTION_TYPE:    acc.rd_data = action_type;
         OFS_ACTION_VERSION: acc.rd_data = action_version;
         OFS_USER_STATUS:    acc.rd_data = status_rd;
         OFS_USER_CONTROL:   acc.rd_data = user_ctrl;
         OFS_SOURCE_ADDR_L:  acc.rd_data = source_address[31:0];
         OFS_SOURCE_ADDR_H:  acc.rd_data = source_address[63:32];
         OFS_TARGET_ADDR_L:  acc.rd_data = target_address[31:0];
         OFS_TARGET_ADDR_H:  acc.rd_data = target_address[63:32];
         OFS_MB_W:           acc.rd_data = mb_w;
         OFS_MB_H:           acc.rd_data = mb_h;
         OFS_SOFT_RESET:     acc.rd_data = srst_reg;
         default:            acc.rd_data = UNMAPPED_READ_VALUE;
      endcase
   end

endmodule
